//--- axi4ToAxi3Read.f
+incdir+common
common/axiRdPkg.sv
src/rdFifo.sv
burstSplit/burstAddrGen.sv
src/rdConvCtrl.sv
src/axi4ToAxi3Read.sv
sim/tbAxi3Slave.sv
sim/axi4ToAxi3ReadTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = axi4ToAxi3ReadTb
FILELIST = axi4ToAxi3Read.f

LOG  = sim.log
BIN  = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) common/axiRd_consts.svh
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/axi4ToAxi3ReadTb.sv
`timescale 1ns/1ps
`include "axiRd_consts.svh"

// Testbench for the AXI4 to AXI3 read converter
module axi4ToAxi3ReadTb;

	localparam int NUM_REQ     = 40;	// Master bursts per run
	localparam int WATCHDOG_NS = NUM_REQ * 256 * 6 * 8;	// 6 cycles a beat, 8 ns clock

	logic                       ACLK;
	logic                       sysReset;
	logic [`AXI_ID_WIDTH-1:0]   mArId;
	logic [`AXI_ADDR_WIDTH-1:0] mArAddr;
	logic [7:0]                 mArLen;
	logic [2:0]                 mArSize;
	axiRdPkg::axiBurstT         mArBurst;
	logic [2:0]                 mArProt;
	logic                       mArValid;
	logic                       mArReady;
	logic [`AXI_ID_WIDTH-1:0]   mRId;
	logic [`AXI_DATA_WIDTH-1:0] mRData;
	logic [1:0]                 mRResp;
	logic                       mRLast;
	logic                       mRValid;
	logic                       mRReady;
	logic [`AXI_ADDR_WIDTH-1:0] sArAddr;
	logic [3:0]                 sArLen;
	logic [2:0]                 sArSize;
	axiRdPkg::axiBurstT         sArBurst;
	logic [2:0]                 sArProt;
	logic                       sArValid;
	logic                       sArReady;
	logic [`AXI_DATA_WIDTH-1:0] sRData;
	logic [1:0]                 sRResp;
	logic                       sRValid;
	logic                       sRReady;

	logic [43:0] expSub[$];	// Addr, len, size, burst, prot per sub-burst
	logic [38:0] expBeat[$];	// Id, data, resp, last per master beat
	logic [43:0] headSub;
	logic [38:0] headBeat;
	logic        allDone   = 1'b0;	// Every expected beat has come back
	int          valueErrs = 0;
	int          otherErrs = 0;
	int          subSeen   = 0;
	int          beatSeen  = 0;

	axi4ToAxi3Read axi4ToAxi3Read_i (.*);
	tbAxi3Slave axi3Slave (.*);

	initial
	begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;	// 8 ns period
	end

	// ========================================================================
	// Reference model
	// ========================================================================
	task automatic predictBursts(input logic [3:0] id, input logic [31:0] addr,
		input logic [7:0] len, input logic [2:0] size, input axiRdPkg::axiBurstT burst,
		input logic [2:0] prot);
		logic [31:0] subAddr;
		logic [3:0]  subLen;
		logic        tail;
		int          nSub;
		int          s;
		int          b;
		subAddr = addr;
		nSub    = int'(len[7:4]) + 1;	// Full bursts plus the tail
		for (s = 0; s < nSub; s++)
		begin
			tail   = (s == nSub - 1);
			subLen = tail ? len[3:0] : 4'd15;
			expSub.push_back({subAddr, subLen, size, burst, prot});
			for (b = 0; b <= int'(subLen); b++)
				expBeat.push_back({id, subAddr + 32'(b), subAddr[12] ? 2'b10 : 2'b00,
					tail && (b == int'(subLen))});
			if (burst == axiRdPkg::INCR)	// Align down, then 16 transfers on
				subAddr = (subAddr & ~((32'd1 << size) - 32'd1)) + (32'd16 << size);
		end
	endtask

	task automatic reportMismatch(input string sigName, input logic [63:0] got,
		input logic [63:0] exp);
		valueErrs++;
		$display("[FAIL] %0t ns %s got %h expected %h", $time, sigName, got, exp);
	endtask

	task automatic printSummary();
		$display("Summary: %0d sub-bursts, %0d beats, %0d value errors, %0d other errors",
			subSeen, beatSeen, valueErrs, otherErrs);
	endtask

	// ========================================================================
	// Monitors at the rising edge
	// ========================================================================
	always @(posedge ACLK)
	begin
		if (sysReset && sArValid && sArReady)
		begin
			subSeen++;
			if (expSub.size() == 0)
			begin
				otherErrs++;
				$display("Error at %0t ns: sub-burst issued with none expected", $time);
			end
			else
			begin
				headSub = expSub.pop_front();
				if ({sArAddr, sArLen, sArSize, sArBurst, sArProt} !== headSub)
					reportMismatch("sArAddr/Len/Size/Burst/Prot",
						64'({sArAddr, sArLen, sArSize, sArBurst, sArProt}), 64'(headSub));
			end
		end
		if (sysReset && mRValid && mRReady)
		begin
			beatSeen++;
			if (expBeat.size() == 0)
			begin
				otherErrs++;
				$display("Error at %0t ns: master beat returned with none expected", $time);
			end
			else
			begin
				headBeat = expBeat.pop_front();
				if ({mRId, mRData, mRResp, mRLast} !== headBeat)
					reportMismatch("mRId/Data/Resp/Last",
						64'({mRId, mRData, mRResp, mRLast}), 64'(headBeat));
			end
		end
		if (allDone && (mRValid || sArValid))	// Both idle once drained
		begin
			otherErrs++;
			$display("Error at %0t ns: mRValid or sArValid high after the last burst", $time);
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	task automatic sendRequest();
		int gap;
		@(negedge ACLK);
		mArId    = 4'($urandom);
		mArAddr  = $urandom;
		mArLen   = 8'($urandom);	// 1 to 256 beats
		mArSize  = 3'($urandom % 3);
		mArBurst = ($urandom % 2) ? axiRdPkg::INCR : axiRdPkg::FIXED;
		mArProt  = 3'($urandom);
		mArValid = 1'b1;
		while (!mArReady)	// Ready only moves at the rising edge
			@(negedge ACLK);
		predictBursts(mArId, mArAddr, mArLen, mArSize, mArBurst, mArProt);
		@(negedge ACLK);	// Handshake done at that rising edge
		mArValid = 1'b0;
		gap = $urandom % 4;
		repeat (gap) @(negedge ACLK);
	endtask

	// Random master stalls
	initial
	begin
		mRReady = 1'b0;
		forever
		begin
			@(negedge ACLK);
			mRReady = ($urandom % 4) != 0;
		end
	end

	initial
	begin
		void'($urandom(32'hba3b));
		sysReset = 1'b0;
		mArId    = '0;
		mArAddr  = '0;
		mArLen   = '0;
		mArSize  = '0;
		mArBurst = axiRdPkg::FIXED;
		mArProt  = '0;
		mArValid = 1'b0;
		repeat (8) @(posedge ACLK);
		@(negedge ACLK);
		sysReset = 1'b1;
		repeat (NUM_REQ) sendRequest();
		while ((expSub.size() != 0) || (expBeat.size() != 0))
			@(negedge ACLK);
		allDone = 1'b1;
		repeat (4) @(negedge ACLK);
		printSummary();
		if ((valueErrs == 0) && (otherErrs == 0))
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout at %0t ns: %0d sub-bursts and %0d beats still outstanding",
			$time, expSub.size(), expBeat.size());
		printSummary();
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sim/tbAxi3Slave.sv
`timescale 1ns/1ps
`include "axiRd_consts.svh"

// Behavioral AXI3 read slave
// Beat data is the sub-burst address plus the beat index
module tbAxi3Slave (
	input  logic                       ACLK,
	input  logic                       sysReset,
	input  logic [`AXI_ADDR_WIDTH-1:0] sArAddr,
	input  logic [3:0]                 sArLen,
	input  logic                       sArValid,
	output logic                       sArReady,
	output logic [`AXI_DATA_WIDTH-1:0] sRData,
	output logic [1:0]                 sRResp,
	output logic                       sRValid,
	input  logic                       sRReady
);

	logic [`AXI_ADDR_WIDTH-1:0] addrQ[$];	// Accepted sub-bursts, oldest first
	logic [3:0]                 lenQ[$];
	logic [3:0]                 beatIdx = 4'd0;	// Next beat of the head sub-burst
	logic                       rTaken = 1'b0;	// Beat taken at the last rising edge

	// Handshakes seen at the rising edge
	always @(posedge ACLK)
	begin
		rTaken = sysReset && sRValid && sRReady;
		if (sysReset && sArValid && sArReady)
		begin
			addrQ.push_back(sArAddr);
			lenQ.push_back(sArLen);
		end
		if (rTaken)
		begin
			if (beatIdx == lenQ[0])	// Sub-burst complete
			begin
				void'(addrQ.pop_front());
				void'(lenQ.pop_front());
				beatIdx = 4'd0;
			end
			else
				beatIdx = beatIdx + 4'd1;
		end
	end

	// Outputs change on the falling edge
	initial
	begin
		sArReady = 1'b0;
		sRValid  = 1'b0;
		sRData   = '0;
		sRResp   = 2'b00;
		forever
		begin
			@(negedge ACLK);
			sArReady = ($urandom % 4) != 0;	// Address stall one cycle in four
			if (sRValid && !rTaken)
				sRValid = 1'b1;	// Offered beat held until taken
			else if ((addrQ.size() != 0) && (($urandom % 3) != 0))
			begin
				sRValid = 1'b1;
				sRData  = addrQ[0] + `AXI_DATA_WIDTH'(beatIdx);
				sRResp  = addrQ[0][12] ? 2'b10 : 2'b00;	// SLVERR when bit 12 set
			end
			else
				sRValid = 1'b0;	// Random gap or nothing pending
		end
	end

endmodule

//--- src/axi4ToAxi3Read.sv
`timescale 1ns/1ps
`include "axiRd_consts.svh"

// AXI4 to AXI3 read burst converter
module axi4ToAxi3Read (
	input  logic                       ACLK,
	input  logic                       sysReset,

	// ========================================================================
	// Master side, AXI4
	// ========================================================================
	input  logic [`AXI_ID_WIDTH-1:0]   mArId,
	input  logic [`AXI_ADDR_WIDTH-1:0] mArAddr,
	input  logic [7:0]                 mArLen,	// Up to 256 beats
	input  logic [2:0]                 mArSize,
	input  axiRdPkg::axiBurstT         mArBurst,
	input  logic [2:0]                 mArProt,
	input  logic                       mArValid,
	output logic                       mArReady,
	output logic [`AXI_ID_WIDTH-1:0]   mRId,
	output logic [`AXI_DATA_WIDTH-1:0] mRData,
	output logic [1:0]                 mRResp,
	output logic                       mRLast,
	output logic                       mRValid,
	input  logic                       mRReady,

	// ========================================================================
	// Slave side, AXI3
	// ========================================================================
	output logic [`AXI_ADDR_WIDTH-1:0] sArAddr,
	output logic [3:0]                 sArLen,	// At most 16 beats
	output logic [2:0]                 sArSize,
	output axiRdPkg::axiBurstT         sArBurst,
	output logic [2:0]                 sArProt,
	output logic                       sArValid,
	input  logic                       sArReady,
	input  logic [`AXI_DATA_WIDTH-1:0] sRData,
	input  logic [1:0]                 sRResp,
	input  logic                       sRValid,
	output logic                       sRReady
);

	localparam int LEN_W  = `AXI_ID_WIDTH + 8;	// ID and LEN
	localparam int DATA_W = `AXI_DATA_WIDTH + 2;	// RDATA and RRESP

	logic              acceptAr;
	logic              advance;
	logic              lastSub;
	logic              lenRd;
	logic              lenFull;
	logic              lenEmpty;
	logic [LEN_W-1:0]  lenHead;
	logic              dataWr;
	logic              dataRd;
	logic              dataFull;
	logic              dataEmpty;
	logic [DATA_W-1:0] dataHead;

	// Master read data fields from the FIFO heads
	assign mRId   = lenHead[LEN_W-1:8];
	assign mRData = dataHead[DATA_W-1:2];
	assign mRResp = dataHead[1:0];

	rdConvCtrl rdConvCtrl_i (
		.ACLK       (ACLK),
		.sysReset   (sysReset),
		.mArValid   (mArValid),
		.mArReady   (mArReady),
		.sArValid   (sArValid),
		.sArReady   (sArReady),
		.lastSub    (lastSub),
		.acceptAr   (acceptAr),
		.advance    (advance),
		.lenFull    (lenFull),
		.lenEmpty   (lenEmpty),
		.lenRd      (lenRd),
		.burstBeats (lenHead[7:0]),
		.dataFull   (dataFull),
		.dataEmpty  (dataEmpty),
		.dataWr     (dataWr),
		.dataRd     (dataRd),
		.sRValid    (sRValid),
		.sRReady    (sRReady),
		.mRValid    (mRValid),
		.mRReady    (mRReady),
		.mRLast     (mRLast)
	);

	burstAddrGen burstAddrGen_i (
		.ACLK     (ACLK),
		.sysReset (sysReset),
		.load     (acceptAr),
		.advance  (advance),
		.arAddr   (mArAddr),
		.arLen    (mArLen),
		.arSize   (mArSize),
		.arBurst  (mArBurst),
		.arProt   (mArProt),
		.slvAddr  (sArAddr),
		.slvLen   (sArLen),
		.slvSize  (sArSize),
		.slvBurst (sArBurst),
		.slvProt  (sArProt),
		.lastSub  (lastSub)
	);

	// ID and LEN of each accepted master burst, in request order
	rdFifo #(.WIDTH(LEN_W), .DEPTH(`LEN_FIFO_DEPTH)) lenFifo (
		.ACLK     (ACLK),
		.sysReset (sysReset),
		.wrEn     (acceptAr),
		.wrData   ({mArId, mArLen}),
		.rdEn     (lenRd),
		.rdData   (lenHead),
		.full     (lenFull),
		.empty    (lenEmpty)
	);

	// Slave beats waiting for the master
	rdFifo #(.WIDTH(DATA_W), .DEPTH(`DATA_FIFO_DEPTH)) dataFifo (
		.ACLK     (ACLK),
		.sysReset (sysReset),
		.wrEn     (dataWr),
		.wrData   ({sRData, sRResp}),
		.rdEn     (dataRd),
		.rdData   (dataHead),
		.full     (dataFull),
		.empty    (dataEmpty)
	);

endmodule

//--- src/rdConvCtrl.sv
`timescale 1ns/1ps

// Control for the read converter
// Address issue FSM, beat return FSM and every FIFO strobe
module rdConvCtrl (
	input  logic       ACLK,
	input  logic       sysReset,

	// Master and slave address handshakes
	input  logic       mArValid,
	output logic       mArReady,
	output logic       sArValid,
	input  logic       sArReady,
	input  logic       lastSub,	// From the address generator
	output logic       acceptAr,	// Load generator and push length entry
	output logic       advance,	// Step to the next sub-burst

	// Length FIFO
	input  logic       lenFull,
	input  logic       lenEmpty,
	output logic       lenRd,
	input  logic [7:0] burstBeats,	// Head entry LEN

	// Data FIFO
	input  logic       dataFull,
	input  logic       dataEmpty,
	output logic       dataWr,
	output logic       dataRd,

	// Read data handshakes
	input  logic       sRValid,
	output logic       sRReady,
	output logic       mRValid,
	input  logic       mRReady,
	output logic       mRLast
);

	axiRdPkg::addrStateT addrState;
	axiRdPkg::addrStateT addrNext;
	axiRdPkg::sendStateT sendState;
	axiRdPkg::sendStateT sendNext;

	logic [7:0] beatCnt;	// Beats left after the current one
	logic       startBurst;	// Load counter from length head
	logic       beatDone;	// Master beat handshake
	logic       lastBeat;	// Counter reached the final beat

	// ========================================================================
	// Address issue
	// ========================================================================
	assign mArReady = (addrState == axiRdPkg::IDLE_ADDR) && !lenFull;	// Room for a length entry
	assign acceptAr = mArValid && mArReady;
	assign sArValid = (addrState == axiRdPkg::ISSUE_ADDR);
	assign advance  = sArValid && sArReady;

	always_comb
	begin
		addrNext = addrState;
		case (addrState)
			axiRdPkg::IDLE_ADDR:
			begin
				if (acceptAr)
					addrNext = axiRdPkg::ISSUE_ADDR;
			end
			axiRdPkg::ISSUE_ADDR:
			begin
				if (advance && lastSub)	// Final sub-burst taken
					addrNext = axiRdPkg::IDLE_ADDR;
			end
			default: addrNext = axiRdPkg::IDLE_ADDR;
		endcase
	end

	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			addrState <= axiRdPkg::IDLE_ADDR;
		else
			addrState <= addrNext;
	end

	// ========================================================================
	// Slave beats into the data FIFO
	// ========================================================================
	assign sRReady = !dataFull;	// Slave RLAST not needed here
	assign dataWr  = sRValid && sRReady;

	// ========================================================================
	// Beat return to the master
	// ========================================================================
	assign startBurst = (sendState == axiRdPkg::IDLE_SEND) && !dataEmpty && !lenEmpty;
	assign lastBeat   = (beatCnt == '0);
	assign mRValid    = (sendState == axiRdPkg::SEND_DATA) && !dataEmpty;
	assign mRLast     = mRValid && lastBeat;
	assign beatDone   = mRValid && mRReady;
	assign dataRd     = beatDone;	// Pop one beat per handshake
	assign lenRd      = beatDone && lastBeat;	// Burst finished so retire its entry

	always_comb
	begin
		sendNext = sendState;
		case (sendState)
			axiRdPkg::IDLE_SEND:
			begin
				if (startBurst)
					sendNext = axiRdPkg::SEND_DATA;
			end
			axiRdPkg::SEND_DATA:
			begin
				if (beatDone && lastBeat)
					sendNext = axiRdPkg::IDLE_SEND;
			end
			default: sendNext = axiRdPkg::IDLE_SEND;
		endcase
	end

	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			sendState <= axiRdPkg::IDLE_SEND;
		else
			sendState <= sendNext;
	end

	// Beat counter, LEN of the head burst counted down to zero
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			beatCnt <= '0;
		else if (startBurst)
			beatCnt <= burstBeats;
		else if (beatDone && !lastBeat)
			beatCnt <= beatCnt - 1'b1;
	end

endmodule

//--- burstSplit/burstAddrGen.sv
`timescale 1ns/1ps
`include "axiRd_consts.svh"

// Splits one AXI4 read request into AXI3 sized sub-bursts
module burstAddrGen (
	input  logic                       ACLK,
	input  logic                       sysReset,
	input  logic                       load,	// Master request accepted
	input  logic                       advance,	// Slave took current sub-burst
	input  logic [`AXI_ADDR_WIDTH-1:0] arAddr,
	input  logic [7:0]                 arLen,
	input  logic [2:0]                 arSize,
	input  axiRdPkg::axiBurstT         arBurst,
	input  logic [2:0]                 arProt,
	output logic [`AXI_ADDR_WIDTH-1:0] slvAddr,
	output logic [3:0]                 slvLen,
	output logic [2:0]                 slvSize,
	output axiRdPkg::axiBurstT         slvBurst,
	output logic [2:0]                 slvProt,
	output logic                       lastSub	// Current sub-burst is the final one
);

	logic [`AXI_ADDR_WIDTH-1:0] curAddr;	// Address of the sub-burst on the bus
	logic [`AXI_ADDR_WIDTH-1:0] nextAddr;	// Address of the one after it
	logic [`AXI_ADDR_WIDTH-1:0] alignMask;	// Clears the sub-size bits
	logic [`AXI_ADDR_WIDTH-1:0] stepBytes;	// Bytes in a full AXI3 burst
	logic [3:0]                 subCnt;	// Sub-bursts left after this one
	logic [3:0]                 lastLen;	// LEN of the tail sub-burst
	logic [2:0]                 latSize;
	axiRdPkg::axiBurstT         latBurst;
	logic [2:0]                 latProt;

	// ========================================================================
	// Address stepping
	// ========================================================================
	assign alignMask = ~((`AXI_ADDR_WIDTH'(1) << latSize) - 1'b1);
	assign stepBytes = `AXI_ADDR_WIDTH'(`AXI3_MAX_LEN + 1) << latSize;	// 16 transfers

	always_comb
	begin
		case (latBurst)
			axiRdPkg::INCR: nextAddr = (curAddr & alignMask) + stepBytes;	// Aligned then stepped
			default:        nextAddr = curAddr;	// FIXED keeps the address
		endcase
	end

	// Request payload, loaded once and stepped per sub-burst
	always_ff @(posedge ACLK)
	begin
		if (load)
		begin
			curAddr  <= arAddr;
			lastLen  <= arLen[3:0];	// Tail length
			latSize  <= arSize;
			latBurst <= arBurst;
			latProt  <= arProt;
		end
		else if (advance)
			curAddr <= nextAddr;
	end

	// Remaining sub-burst count
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			subCnt <= '0;
		else if (load)
			subCnt <= arLen[7:4];	// Upper bits give full bursts
		else if (advance && (subCnt != '0))
			subCnt <= subCnt - 1'b1;
	end

	// ========================================================================
	// Slave address channel fields
	// ========================================================================
	assign lastSub  = (subCnt == '0);
	assign slvLen   = lastSub ? lastLen : 4'(`AXI3_MAX_LEN);	// Full 16 beats until the tail
	assign slvAddr  = curAddr;
	assign slvSize  = latSize;
	assign slvBurst = latBurst;
	assign slvProt  = latProt;

endmodule

//--- src/rdFifo.sv
`timescale 1ns/1ps

// Synchronous FIFO with a combinational head
module rdFifo #(
	parameter int WIDTH = 8,	// Entry width
	parameter int DEPTH = 16	// Number of entries
)(
	input  logic             ACLK,
	input  logic             sysReset,
	input  logic             wrEn,	// Push, dropped when full
	input  logic [WIDTH-1:0] wrData,
	input  logic             rdEn,	// Pop, dropped when empty
	output logic [WIDTH-1:0] rdData,	// Current head
	output logic             full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);	// Holds 0..DEPTH

	logic [WIDTH-1:0] mem [DEPTH];	// Storage array
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;	// Occupancy
	logic             doWr;	// Qualified push
	logic             doRd;	// Qualified pop

	assign doWr   = wrEn && !full;
	assign doRd   = rdEn && !empty;
	assign full   = (count == CNT_W'(DEPTH));
	assign empty  = (count == '0);
	assign rdData = mem[rdPtr];	// Head visible the cycle after the write

	// Storage write
	always_ff @(posedge ACLK)
	begin
		if (doWr)
			mem[wrPtr] <= wrData;
	end

	// Pointers and occupancy
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;	// Wrap at end
			if (doRd)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doWr, doRd})
				2'b10:   count <= count + 1'b1;	// Push only
				2'b01:   count <= count - 1'b1;	// Pop only
				default: count <= count;	// Both or neither
			endcase
		end
	end

endmodule

//--- common/axiRdPkg.sv
// ============================================================================
// Shared types for the AXI4 to AXI3 read converter
// ============================================================================
package axiRdPkg;

	// AXI burst type encoding as carried on ARBURST
	typedef enum logic [1:0]
	{
		FIXED = 2'b00,	// Every beat at the same address
		INCR  = 2'b01,	// Address steps by transfer size
		WRAP  = 2'b10	// Encoded for completeness only
	} axiBurstT;

	// Address issue FSM
	// IDLE_ADDR waits for a master request
	// ISSUE_ADDR presents sub-bursts to the slave until the last one is taken
	typedef enum logic
	{
		IDLE_ADDR  = 1'b0,	// Ready for a new master request
		ISSUE_ADDR = 1'b1	// Sub-bursts going out
	} addrStateT;

	// Beat return FSM
	// IDLE_SEND waits for a length entry and the first data beat
	// SEND_DATA streams beats to the master until the counter runs out
	typedef enum logic
	{
		IDLE_SEND = 1'b0,	// Waiting for the next burst
		SEND_DATA = 1'b1	// Master burst in progress
	} sendStateT;

endpackage

//--- common/axiRd_consts.svh
`ifndef AXIRD_CONSTS_SVH
`define AXIRD_CONSTS_SVH

// ============================================================================
// Bus widths
// ============================================================================
`define AXI_ADDR_WIDTH 32	// Byte address
`define AXI_DATA_WIDTH 32	// RDATA width
`define AXI_ID_WIDTH 4	// Master side ID

// AXI3 burst limit, LEN field of a 16 beat burst
`define AXI3_MAX_LEN 15

// ============================================================================
// Buffer depths
// ============================================================================
`define LEN_FIFO_DEPTH 8	// Master bursts in flight
`define DATA_FIFO_DEPTH 16	// Read beats buffered

`endif
